// ==== link_8b9b_pkg.sv ====
/*
 * Shared definitions for the 8b9b serial link
 * Byte and bus widths, oversampling factor
 * Register map, receiver and transmitter state encodings
 */

package link_8b9b_pkg;

	// Data bits in one byte slot on the line
	localparam int WORD_WIDTH = 8;

	// Rx FIFO entry holds the byte plus the last-of-frame tag
	localparam int RX_WORD_WIDTH = WORD_WIDTH + 1;

	// Samples per bit, fixed by the latch point logic in the receiver
	localparam int OVERSAMPLE = 4;

	localparam int WB_DATA_WIDTH = 32;	// Wishbone data bus

	// Word addresses of the host registers
	typedef enum logic [1:0] {
		REG_DATA   = 2'd0,	// Write pushes tx byte, read pops rx word
		REG_STATUS = 2'd1,	// Counts, busy, sticky overflow
		REG_CTRL   = 2'd2,	// Bit 0 send, bit 1 rx enable
		REG_RSVD   = 2'd3	// Reads as zero
	} reg_addr_e;

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE    = 2'd0,	// Waiting for a low sample
		RX_ALIGN   = 2'd1,	// One cycle for the retimed bit to settle
		RX_RECEIVE = 2'd2,	// Shifting data bits
		RX_COMMIT  = 2'd3	// Word out, flag decides next state
	} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,	// Start bit on the line
		TX_DATA  = 2'd2,	// Data bits, LSB first
		TX_FLAG  = 2'd3		// Continuation bit
	} tx_state_e;

endpackage

// ==== word_fifo.sv ====
/*
 * Synchronous FIFO with push/pop interface
 * Circular buffer, registered count, head shown on dout
 */

`timescale 1ns/1ns

module word_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16	// Power of two
) (
	input  logic                   clk,
	input  logic                   sync_reset,
	input  logic                   push,
	input  logic [WIDTH-1:0]       din,
	input  logic                   pop,
	output logic [WIDTH-1:0]       dout,
	output logic                   empty,
	output logic                   full,
	output logic [$clog2(DEPTH):0] count
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	// Push on full and pop on empty are dropped here
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == DEPTH[PTR_W:0]);
	assign dout  = mem[rd_ptr];	// Head entry, no read latency

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== tx_8b9b.sv ====
/*
 * 8b9b framer and serializer
 * Latches frame length on send, pops one byte per slot
 * Start bit, 8 data bits LSB first, continuation flag
 */

`timescale 1ns/1ns

module tx_8b9b
	import link_8b9b_pkg::*;
#(
	parameter int DEPTH = 16	// Tx FIFO depth, sets the count width
) (
	input  logic                   clk,
	input  logic                   sync_reset,
	input  logic                   send,
	input  logic [$clog2(DEPTH):0] fifo_count,
	input  logic [WORD_WIDTH-1:0]  fifo_dout,
	input  logic                   fifo_empty,
	output logic                   fifo_pop,
	output logic                   busy,
	output logic [OVERSAMPLE-1:0]  tx_samples
);

	localparam int BIT_CW = $clog2(WORD_WIDTH);

	tx_state_e              state;
	logic [$clog2(DEPTH):0] remaining;	// Bytes still to load after the current one
	logic [BIT_CW-1:0]      bit_cnt;	// Data bits left after the one on the line
	logic [WORD_WIDTH-1:0]  shift_reg;
	logic                   tx_bit;	// Current line level
	logic                   load;

	// Next byte is taken after the start bit and after each flag of 0
	assign load = (state == TX_START) || (state == TX_FLAG && remaining != '0);

	assign fifo_pop   = load;
	assign busy       = (state != TX_IDLE);
	assign tx_samples = {OVERSAMPLE{tx_bit}};	// Whole bit period at one level

	// Byte shifter, bit 0 goes out the same edge it is loaded
	always_ff @(posedge clk) begin
		if (load)
			shift_reg <= fifo_dout;
		else if (state == TX_DATA)
			shift_reg <= {1'b0, shift_reg[WORD_WIDTH-1:1]};
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			state     <= TX_IDLE;
			tx_bit    <= 1'b1;	// Line idles high
			remaining <= '0;
			bit_cnt   <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					// Send with nothing queued is dropped
					if (send && !fifo_empty) begin
						remaining <= fifo_count;	// Frame length fixed here
						tx_bit    <= 1'b0;	// Start bit
						state     <= TX_START;
					end
				end
				TX_START: begin
					tx_bit    <= fifo_dout[0];
					bit_cnt   <= BIT_CW'(WORD_WIDTH - 1);
					remaining <= remaining - 1'b1;
					state     <= TX_DATA;
				end
				TX_DATA: begin
					if (bit_cnt == '0) begin
						// Flag is 1 after the last latched byte
						tx_bit <= (remaining == '0);
						state  <= TX_FLAG;
					end else begin
						tx_bit  <= shift_reg[1];	// Next bit before the shift lands
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				TX_FLAG: begin
					if (remaining != '0) begin
						// Straight into the next byte, no start bit
						tx_bit    <= fifo_dout[0];
						bit_cnt   <= BIT_CW'(WORD_WIDTH - 1);
						remaining <= remaining - 1'b1;
						state     <= TX_DATA;
					end else begin
						tx_bit <= 1'b1;	// Back to idle level
						state  <= TX_IDLE;
					end
				end
				default: begin
					tx_bit <= 1'b1;
					state  <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== rx_8b9b.sv ====
/*
 * Oversampled 8b9b receiver
 * Start detect on any low sample, latch point one sample later
 * Shifts 8 bits LSB first, flag bit tags the word as last of frame
 */

`timescale 1ns/1ns

module rx_8b9b
	import link_8b9b_pkg::*;
(
	input  logic                  clk,
	input  logic                  sync_reset,
	input  logic                  enable,
	input  logic [OVERSAMPLE-1:0] rx_samples,	// Sample 0 earliest
	output logic [WORD_WIDTH-1:0] word_out,
	output logic                  word_last,
	output logic                  word_write
);

	localparam int LP_W   = $clog2(OVERSAMPLE);
	localparam int BIT_CW = $clog2(WORD_WIDTH);

	rx_state_e             state;
	logic [OVERSAMPLE-1:0] int_data;	// Registered samples
	logic [OVERSAMPLE-1:0] r_int_data;	// Previous vector
	logic                  n_start_detect;	// Low when any sample is low
	logic [LP_W-1:0]       int_latch_point;
	logic [LP_W-1:0]       latch_point;	// Held for the whole frame
	logic                  int_bit;	// Selected bit, one per clk
	logic [BIT_CW-1:0]     bit_counter;
	logic [WORD_WIDTH-1:0] int_result;

	// Input registers, reset high so no false start comes out of reset
	always_ff @(posedge clk) begin
		if (sync_reset) begin
			int_data       <= '1;
			n_start_detect <= 1'b1;
		end else begin
			int_data       <= rx_samples;
			n_start_detect <= &int_data;
		end
	end

	// Latch point and bit selection
	always_ff @(posedge clk) begin
		// One sample after the first low one
		// Low at sample 3 wraps to sample 0 of the next vector
		int_latch_point <= !int_data[0] ? LP_W'(1) :
			!int_data[1] ? LP_W'(2) :
			!int_data[2] ? LP_W'(3) :
			LP_W'(0);
		r_int_data <= int_data;
		// Point 0 is a vector later than the others
		// Take it from the current vector and the rest from the retimed one
		if (latch_point == '0)
			int_bit <= int_data[0];
		else
			int_bit <= r_int_data[latch_point];
	end

	// Data shifter and output word
	always_ff @(posedge clk) begin
		if (state == RX_RECEIVE)
			int_result <= {int_bit, int_result[WORD_WIDTH-1:1]};	// LSB arrives first
		if (state == RX_COMMIT) begin
			word_out  <= int_result;
			word_last <= int_bit;	// Flag bit sits on int_bit at commit
		end
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			state       <= RX_IDLE;
			latch_point <= '0;
			bit_counter <= '0;
			word_write  <= 1'b0;
		end else begin
			word_write <= 1'b0;
			case (state)
				RX_IDLE: begin
					// Enable only checked here so a running frame finishes
					if (enable && !n_start_detect) begin
						latch_point <= int_latch_point;
						bit_counter <= BIT_CW'(WORD_WIDTH - 1);
						state       <= RX_ALIGN;
					end
				end
				RX_ALIGN: begin
					state <= RX_RECEIVE;	// int_bit follows the new latch point now
				end
				RX_RECEIVE: begin
					bit_counter <= bit_counter - 1'b1;
					if (bit_counter == '0)
						state <= RX_COMMIT;
				end
				RX_COMMIT: begin
					word_write  <= 1'b1;
					bit_counter <= BIT_CW'(WORD_WIDTH - 1);
					// Flag 0 means the next byte follows at once
					if (int_bit)
						state <= RX_IDLE;
					else
						state <= RX_RECEIVE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

// ==== wb_link_regs.sv ====
/*
 * Wishbone classic slave for the link
 * DATA, STATUS and CTRL registers, FIFO push/pop strobes
 * Send pulse, rx enable and sticky rx overflow
 */

`timescale 1ns/1ns

module wb_link_regs
	import link_8b9b_pkg::*;
#(
	parameter int TX_DEPTH = 16,
	parameter int RX_DEPTH = 16
) (
	input  logic                         clk,
	input  logic                         sync_reset,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  reg_addr_e                    wb_adr,
	input  logic [WB_DATA_WIDTH-1:0]     wb_dat_w,
	output logic [WB_DATA_WIDTH-1:0]     wb_dat_r,
	output logic                         wb_ack,
	output logic                         tx_push,
	output logic [WORD_WIDTH-1:0]        tx_din,
	input  logic                         tx_full,
	input  logic [$clog2(TX_DEPTH):0]    tx_count,
	output logic                         tx_send,
	input  logic                         tx_busy,
	output logic                         rx_enable,
	output logic                         rx_pop,
	input  logic [RX_WORD_WIDTH-1:0]     rx_dout,
	input  logic                         rx_empty,
	input  logic                         rx_full,
	input  logic [$clog2(RX_DEPTH):0]    rx_count,
	input  logic                         rx_push_seen
);

	localparam int TX_CW       = $clog2(TX_DEPTH) + 1;
	localparam int RX_CW       = $clog2(RX_DEPTH) + 1;
	localparam int COUNT_FIELD = 8;	// Width of each count field in STATUS

	logic                     access;	// Cycle of a new transfer
	logic                     wr;
	logic                     rd;
	logic                     rx_overflow;
	logic [WB_DATA_WIDTH-1:0] status_word;
	logic [WB_DATA_WIDTH-1:0] rd_data;

	// Transfer starts when ack is still low
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr     = access && wb_we;
	assign rd     = access && !wb_we;

	// Strobes act on the same edge that raises ack
	assign tx_push = wr && (wb_adr == REG_DATA) && !tx_full;
	assign tx_din  = wb_dat_w[WORD_WIDTH-1:0];
	assign tx_send = wr && (wb_adr == REG_CTRL) && wb_dat_w[0];	// Ignored in tx while busy
	assign rx_pop  = rd && (wb_adr == REG_DATA) && !rx_empty;

	assign status_word = {
		{(WB_DATA_WIDTH - 2 - 2*COUNT_FIELD){1'b0}},
		rx_overflow,
		tx_busy,
		{(COUNT_FIELD - TX_CW){1'b0}}, tx_count,
		{(COUNT_FIELD - RX_CW){1'b0}}, rx_count
	};

	always_comb begin
		case (wb_adr)
			REG_DATA: begin
				// Empty FIFO reads as zero
				if (rx_empty)
					rd_data = '0;
				else
					rd_data = {{(WB_DATA_WIDTH - RX_WORD_WIDTH){1'b0}}, rx_dout};
			end
			REG_STATUS: rd_data = status_word;
			default:    rd_data = '0;	// CTRL is write only
		endcase
	end

	// Read data captured with the pop, held while ack is high
	always_ff @(posedge clk) begin
		if (rd)
			wb_dat_r <= rd_data;
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			wb_ack      <= 1'b0;
			rx_enable   <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			wb_ack <= access;	// Single cycle ack
			if (wr && wb_adr == REG_CTRL)
				rx_enable <= wb_dat_w[1];
			// Set beats the clear from a STATUS read in the same cycle
			if (rx_push_seen && rx_full)
				rx_overflow <= 1'b1;
			else if (rd && wb_adr == REG_STATUS)
				rx_overflow <= 1'b0;
		end
	end

endmodule

// ==== link_8b9b_top.sv ====
/*
 * Top level of the 8b9b link
 * Register block, tx and rx FIFOs, transmitter and receiver
 */

`timescale 1ns/1ns

module link_8b9b_top
	import link_8b9b_pkg::*;
#(
	parameter int TX_DEPTH = 16,
	parameter int RX_DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     sync_reset,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  reg_addr_e                wb_adr,
	input  logic [WB_DATA_WIDTH-1:0] wb_dat_w,
	output logic [WB_DATA_WIDTH-1:0] wb_dat_r,
	output logic                     wb_ack,
	output logic [OVERSAMPLE-1:0]    tx_samples,
	input  logic [OVERSAMPLE-1:0]    rx_samples
);

	// Tx path
	logic                        tx_push;
	logic [WORD_WIDTH-1:0]       tx_din;
	logic                        tx_pop;
	logic [WORD_WIDTH-1:0]       tx_dout;
	logic                        tx_empty;
	logic                        tx_full;
	logic [$clog2(TX_DEPTH):0]   tx_count;
	logic                        tx_send;
	logic                        tx_busy;

	// Rx path
	logic                        rx_enable;
	logic                        rx_pop;
	logic [RX_WORD_WIDTH-1:0]    rx_dout;
	logic                        rx_empty;
	logic                        rx_full;
	logic [$clog2(RX_DEPTH):0]   rx_count;
	logic [WORD_WIDTH-1:0]       rx_word;
	logic                        rx_last;
	logic                        rx_write;	// Also feeds overflow detection

	wb_link_regs #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) u_wb_link_regs (
		.clk(clk), .sync_reset(sync_reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.tx_push(tx_push), .tx_din(tx_din), .tx_full(tx_full), .tx_count(tx_count),
		.tx_send(tx_send), .tx_busy(tx_busy), .rx_enable(rx_enable), .rx_pop(rx_pop),
		.rx_dout(rx_dout), .rx_empty(rx_empty), .rx_full(rx_full), .rx_count(rx_count),
		.rx_push_seen(rx_write)
	);

	word_fifo #(.WIDTH(WORD_WIDTH), .DEPTH(TX_DEPTH)) u_tx_fifo (
		.clk(clk), .sync_reset(sync_reset), .push(tx_push), .din(tx_din), .pop(tx_pop),
		.dout(tx_dout), .empty(tx_empty), .full(tx_full), .count(tx_count)
	);

	// Rx entry is {last tag, byte}
	word_fifo #(.WIDTH(RX_WORD_WIDTH), .DEPTH(RX_DEPTH)) u_rx_fifo (
		.clk(clk), .sync_reset(sync_reset), .push(rx_write), .din({rx_last, rx_word}),
		.pop(rx_pop), .dout(rx_dout), .empty(rx_empty), .full(rx_full), .count(rx_count)
	);

	tx_8b9b #(.DEPTH(TX_DEPTH)) u_tx_8b9b (
		.clk(clk), .sync_reset(sync_reset), .send(tx_send), .fifo_count(tx_count),
		.fifo_dout(tx_dout), .fifo_empty(tx_empty), .fifo_pop(tx_pop), .busy(tx_busy),
		.tx_samples(tx_samples)
	);

	rx_8b9b u_rx_8b9b (
		.clk(clk), .sync_reset(sync_reset), .enable(rx_enable), .rx_samples(rx_samples),
		.word_out(rx_word), .word_last(rx_last), .word_write(rx_write)
	);

endmodule

// ==== tb_link_8b9b.sv ====
/*
 * Testbench for the 8b9b link top level
 * Clock, reset, LCG stimulus, phase-shifting loopback
 * Reference words, tx line format, Wishbone tasks, compare process
 */

`timescale 1ns/1ns

module tb_link_8b9b
	import link_8b9b_pkg::*;
();

	localparam int DEPTH        = 16;
	localparam int ACK_TIMEOUT  = 20;	// Cycles allowed for one ack
	localparam int POLL_LIMIT   = 100;	// STATUS reads while tx is busy
	localparam int IDLE_RUN     = 12;	// Quiet line cycles, covers rx latency
	localparam int IDLE_TIMEOUT = 400;
	localparam int DRAIN_LIMIT  = 100;
	localparam logic [WB_DATA_WIDTH-1:0] BUSY_MASK = 32'h0001_0000;

	logic                     clk;
	logic                     sync_reset;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	reg_addr_e                wb_adr;
	logic [WB_DATA_WIDTH-1:0] wb_dat_w;
	logic [WB_DATA_WIDTH-1:0] wb_dat_r;
	logic                     wb_ack;
	logic [OVERSAMPLE-1:0]    tx_samples;
	logic [OVERSAMPLE-1:0]    rx_samples;

	logic [OVERSAMPLE-1:0]    prev_tx;	// Vector of the previous clk
	int                       phase;	// Loopback delay in samples
	logic [31:0]              lcg_state;
	logic                     rx_en;	// Mirror of CTRL bit 1
	logic [WORD_WIDTH-1:0]    frame_bytes[$];
	logic [RX_WORD_WIDTH-1:0] exp_q[$];	// Reference words in order
	logic [RX_WORD_WIDTH-1:0] act_q[$];	// Words read from DATA
	logic                     line_q[$];	// Expected tx line bits, one per clk
	logic                     in_frame;	// Tx line is inside a frame
	int                       words_expected;
	int                       words_checked;

	link_8b9b_top #(.TX_DEPTH(DEPTH), .RX_DEPTH(DEPTH)) u_link_8b9b_top (
		.clk(clk), .sync_reset(sync_reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.tx_samples(tx_samples), .rx_samples(rx_samples)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// Sample 0 of prev is the oldest in the stream
	function automatic logic [OVERSAMPLE-1:0] delay_line(
		input logic [OVERSAMPLE-1:0] cur,
		input logic [OVERSAMPLE-1:0] prev,
		input int                    shift
	);
		logic [2*OVERSAMPLE-1:0] stream;
		stream = {cur, prev};
		return stream[OVERSAMPLE - shift +: OVERSAMPLE];
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Byte tagged as last only in the final slot of its frame
	function automatic logic [RX_WORD_WIDTH-1:0] expected_word(
		input logic [WORD_WIDTH-1:0] data,
		input int                    pos,
		input int                    len
	);
		logic last;
		last = (pos == len - 1);
		return {last, data};
	endfunction

	function automatic logic [WB_DATA_WIDTH-1:0] status_value(
		input int   rx_cnt,
		input int   tx_cnt,
		input logic busy,
		input logic ovf
	);
		logic [WB_DATA_WIDTH-1:0] v;
		v       = '0;
		v[7:0]  = rx_cnt[7:0];
		v[15:8] = tx_cnt[7:0];
		v[16]   = busy;
		v[17]   = ovf;	// Sticky until a STATUS read
		return v;
	endfunction

	function automatic logic [WB_DATA_WIDTH-1:0] ctrl_value(input logic send);
		return {{(WB_DATA_WIDTH - 2){1'b0}}, rx_en, send};
	endfunction

	task automatic check_word(
		input logic [RX_WORD_WIDTH-1:0] exp,
		input logic [RX_WORD_WIDTH-1:0] act
	);
		if (act !== exp) begin
			$display("Fail wb_dat_r rx word: expected 0x%03h, actual 0x%03h", exp, act);
			$display("TEST FAILED");
			$fatal(1, "rx word mismatch");
		end
	endtask

	task automatic check_status(
		input logic [WB_DATA_WIDTH-1:0] exp,
		input logic [WB_DATA_WIDTH-1:0] act,
		input logic [WB_DATA_WIDTH-1:0] mask
	);
		if ((act & mask) !== (exp & mask)) begin
			$display("Fail wb_dat_r status: expected 0x%08h, actual 0x%08h",
				exp & mask, act & mask);
			$display("TEST FAILED");
			$fatal(1, "status mismatch");
		end
	endtask

	// Each line bit fills all four samples and the idle line is high
	task automatic check_line(input logic [OVERSAMPLE-1:0] act);
		logic [OVERSAMPLE-1:0] exp;
		logic                  line_bit;
		exp = '1;
		if (line_q.size() != 0 && (in_frame || act != '1)) begin
			in_frame = 1'b1;	// Frame opens on the first non-idle vector
			line_bit = line_q.pop_front();
			exp      = {OVERSAMPLE{line_bit}};
			if (line_q.size() == 0)
				in_frame = 1'b0;
		end
		if (act !== exp) begin
			$display("Fail tx_samples: expected 0x%01h, actual 0x%01h", exp, act);
			$display("TEST FAILED");
			$fatal(1, "tx line mismatch");
		end
	endtask

	// Entered and left 5 ns after a rising edge
	task automatic wb_write(input reg_addr_e adr, input logic [WB_DATA_WIDTH-1:0] data);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		do begin
			@(posedge clk);
			#5;
			waited++;
			if (!wb_ack && waited >= ACK_TIMEOUT) begin
				$display("No Wishbone ack for a write to %s", adr.name());
				$display("TEST FAILED");
				$fatal(1, "write ack timeout");
			end
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk);	// Idle cycle between transfers
		#5;
	endtask

	task automatic wb_read(input reg_addr_e adr, output logic [WB_DATA_WIDTH-1:0] data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do begin
			@(posedge clk);
			#5;
			waited++;
			if (!wb_ack && waited >= ACK_TIMEOUT) begin
				$display("No Wishbone ack for a read from %s", adr.name());
				$display("TEST FAILED");
				$fatal(1, "read ack timeout");
			end
		end while (!wb_ack);
		data   = wb_dat_r;	// Valid while ack is high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(posedge clk);
		#5;
	endtask

	task automatic wait_tx_idle();
		logic [WB_DATA_WIDTH-1:0] st;
		int                       polls;
		polls = 0;
		do begin
			wb_read(REG_STATUS, st);
			polls++;
			if (st[16] && polls >= POLL_LIMIT) begin
				$display("Transmitter still busy after %0d status polls", polls);
				$display("TEST FAILED");
				$fatal(1, "tx busy timeout");
			end
		end while (st[16]);
	endtask

	// Receiver has committed once the looped line stays high long enough
	task automatic wait_line_idle();
		int quiet;
		int waited;
		quiet  = 0;
		waited = 0;
		while (quiet < IDLE_RUN) begin
			@(posedge clk);
			if (rx_samples == '1)
				quiet++;
			else
				quiet = 0;
			waited++;
			if (quiet < IDLE_RUN && waited >= IDLE_TIMEOUT) begin
				$display("Loopback line never went quiet");
				$display("TEST FAILED");
				$fatal(1, "line idle timeout");
			end
		end
		#5;
	endtask

	task automatic make_random_frame(input int len);
		frame_bytes.delete();
		repeat (len) begin
			lcg_state = lcg_next(lcg_state);
			frame_bytes.push_back(lcg_state[23:16]);
		end
	endtask

	// Words past the limit are the ones a full rx FIFO drops
	task automatic queue_expected(input int limit);
		foreach (frame_bytes[i]) begin
			if (i < limit) begin
				exp_q.push_back(expected_word(frame_bytes[i], i, frame_bytes.size()));
				words_expected++;
			end
		end
	endtask

	// Start bit, data LSB first, then the continuation flag of each byte
	task automatic queue_line();
		line_q.push_back(1'b0);
		foreach (frame_bytes[i]) begin
			for (int b = 0; b < WORD_WIDTH; b++)
				line_q.push_back(frame_bytes[i][b]);
			line_q.push_back(i == frame_bytes.size() - 1);	// 1 only after the last byte
		end
	endtask

	task automatic send_frame(input int rx_before);
		logic [WB_DATA_WIDTH-1:0] st;
		queue_line();
		foreach (frame_bytes[i])
			wb_write(REG_DATA, {{(WB_DATA_WIDTH - WORD_WIDTH){1'b0}}, frame_bytes[i]});
		wb_read(REG_STATUS, st);	// tx_count before send
		check_status(status_value(rx_before, frame_bytes.size(), 1'b0, 1'b0), st, '1);
		wb_write(REG_CTRL, ctrl_value(1'b1));
		wb_read(REG_STATUS, st);
		check_status(status_value(0, 0, 1'b1, 1'b0), st, BUSY_MASK);	// Mid frame
	endtask

	task automatic finish_frame(input int rx_after, input logic ovf);
		logic [WB_DATA_WIDTH-1:0] st;
		wait_tx_idle();
		wait_line_idle();
		wb_read(REG_STATUS, st);
		check_status(status_value(rx_after, 0, 1'b0, ovf), st, '1);
	endtask

	task automatic drain_rx(input int n);
		logic [WB_DATA_WIDTH-1:0] d;
		logic [WB_DATA_WIDTH-1:0] st;
		int                       i;
		for (i = 0; i < n; i++) begin
			wb_read(REG_DATA, d);
			act_q.push_back(d[RX_WORD_WIDTH-1:0]);
		end
		wb_read(REG_STATUS, st);	// FIFO empty again
		check_status(status_value(0, 0, 1'b0, 1'b0), st, '1);
	endtask

	// Line model, tx checked against the frame format and delayed by phase samples
	initial begin
		prev_tx    = '1;
		rx_samples = '1;	// High until the first frame
		in_frame   = 1'b0;
		forever begin
			@(posedge clk);
			#5;
			if (sync_reset) begin
				prev_tx    = '1;
				rx_samples = '1;
			end else begin
				check_line(tx_samples);
				rx_samples = delay_line(tx_samples, prev_tx, phase);
				prev_tx    = tx_samples;
			end
		end
	end

	// Compare process, one read word against the next reference word
	always @(posedge clk) begin
		if (act_q.size() != 0) begin
			if (exp_q.size() == 0) begin
				$display("A word was read back with no reference word pending");
				$display("TEST FAILED");
				$fatal(1, "unexpected rx word");
			end else begin
				check_word(exp_q.pop_front(), act_q.pop_front());
				words_checked++;
			end
		end
	end

	initial begin
		logic [WB_DATA_WIDTH-1:0] st;
		int                       p;
		int                       len;
		int                       waited;
		sync_reset     = 1'b1;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = REG_DATA;
		wb_dat_w       = '0;
		phase          = 0;
		lcg_state      = 32'd93971;
		rx_en          = 1'b0;
		words_expected = 0;
		words_checked  = 0;
		repeat (8) @(posedge clk);
		#5;
		sync_reset = 1'b0;
		@(posedge clk);
		#5;

		// Single byte, phase 0
		rx_en = 1'b1;
		wb_write(REG_CTRL, ctrl_value(1'b0));
		frame_bytes.delete();
		frame_bytes.push_back(8'hA5);
		queue_expected(1);
		send_frame(0);
		finish_frame(1, 1'b0);
		drain_rx(1);

		// 1 to 5 random bytes at every sample phase
		for (p = 0; p < OVERSAMPLE; p++) begin
			phase = p;	// Line is idle here
			for (len = 1; len <= 5; len++) begin
				make_random_frame(len);
				queue_expected(len);
				send_frame(0);
				finish_frame(len, 1'b0);
				drain_rx(len);
			end
		end

		// Rx disabled, frame is lost, then received again once enabled
		phase = 1;
		rx_en = 1'b0;
		wb_write(REG_CTRL, ctrl_value(1'b0));
		make_random_frame(3);
		send_frame(0);
		finish_frame(0, 1'b0);
		rx_en = 1'b1;
		wb_write(REG_CTRL, ctrl_value(1'b0));
		make_random_frame(4);
		queue_expected(4);
		send_frame(0);
		finish_frame(4, 1'b0);
		drain_rx(4);

		// 20 bytes into a 16 deep rx FIFO, last 4 dropped
		phase = 2;
		make_random_frame(10);
		queue_expected(10);
		send_frame(0);
		finish_frame(10, 1'b0);
		make_random_frame(10);
		queue_expected(DEPTH - 10);
		send_frame(10);
		finish_frame(DEPTH, 1'b1);
		wb_read(REG_STATUS, st);	// Overflow cleared by the read before
		check_status(status_value(DEPTH, 0, 1'b0, 1'b0), st, '1);
		drain_rx(DEPTH);

		waited = 0;
		while (act_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			#5;
			waited++;
		end
		if (act_q.size() == 0 && exp_q.size() == 0 && words_checked == words_expected &&
			line_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("Checks incomplete, %0d of %0d words compared, %0d line bits unseen",
				words_checked, words_expected, line_q.size());
			$display("TEST FAILED");
			$fatal(1, "compare incomplete");
		end
	end

endmodule

// ==== vlog.f ====
link_8b9b_pkg.sv
word_fifo.sv
tx_8b9b.sv
rx_8b9b.sv
wb_link_regs.sv
link_8b9b_top.sv
tb_link_8b9b.sv

// ==== Makefile ====
# Verilator build and run of the 8b9b link testbench

VERILATOR ?= verilator
TOP       ?= tb_link_8b9b
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
